// ==== design/io_map_pkg.sv ====
package io_map_pkg;

	// host CPU register window, all three sit in the 0x40xx page
	localparam logic [15:0] CPU_REG_FIFO_DATA = 16'h40F0; // data byte of the FIFO pair
	localparam logic [15:0] CPU_REG_FIFO_STAT = 16'h40F1; // empty flags of both FIFOs
	localparam logic [15:0] CPU_REG_STATUS    = 16'h40FF; // toggle, pend bits and signature

	// SPI command byte, first byte of every transaction
	localparam logic [7:0] CMD_MEM_WR = 8'hA0;
	localparam logic [7:0] CMD_MEM_RD = 8'hA1;

	// peripheral address space as seen from the SPI side
	// the config bytes occupy eight consecutive addresses, bits [2:0] pick the byte
	localparam logic [31:0] PI_CFG_BASE  = 32'h0001_8000;
	localparam logic [31:0] PI_FIFO_ADDR = 32'h0001_8100; // single port for both FIFO directions

	// both FIFOs hold this many bytes
	localparam int FIFO_DEPTH = 16;

	// fixed upper nibble of the status register
	localparam logic [3:0] STATUS_SIG = 4'hA;

	// system configuration block
	localparam int CFG_BYTES = 8;
	localparam int SYS_CFG_W = 64; // CFG_BYTES times eight bits

endpackage

// ==== design/io_bus_pkg.sv ====
package io_bus_pkg;

	// one byte of payload on either bus
	typedef logic [7:0] data_t;

	// host CPU access, one strobe cycle per access
	typedef struct packed
	{
		logic [15:0] addr;
		data_t       wdata;
		logic        rw;     // 1 for a read
		logic        strobe; // access is live this cycle
	} cpu_bus_t;

	// request from the SPI target toward the register block
	// valid is a single cycle pulse and there is no back-pressure
	typedef struct packed
	{
		logic        valid;
		logic        we;    // 1 writes wdata, 0 reads
		logic [31:0] addr;
		data_t       wdata;
	} pi_req_t;

endpackage

// ==== design/byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo
#(
	parameter int DEPTH = io_map_pkg::FIFO_DEPTH
)
(
	input  logic              clk,
	input  logic              rst,
	input  logic              push,
	input  io_bus_pkg::data_t wdata,
	input  logic              pop,
	output io_bus_pkg::data_t rdata,
	output logic              empty,
	output logic              full
);

	localparam int AW = $clog2(DEPTH);

	io_bus_pkg::data_t mem [DEPTH];
	logic [AW:0]       wr_ptr;
	logic [AW:0]       rd_ptr;
	logic              do_push;
	logic              do_pop;

	// the extra pointer bit tells a full buffer from an empty one
	assign empty = wr_ptr == rd_ptr;
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign do_push = push & ~full;  // a push into a full buffer is lost
	assign do_pop  = pop & ~empty;

	// show-ahead so the head byte is readable without a pop
	assign rdata = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr[AW-1:0]] <= wdata;
	end

endmodule

// ==== design/spi_target.sv ====
`timescale 1ns/1ps

module spi_target
(
	input  logic                clk,
	input  logic                rst,
	input  logic                sck,
	input  logic                mosi,
	input  logic                ss_n,
	output logic                miso,
	output io_bus_pkg::pi_req_t pi_req,
	input  io_bus_pkg::data_t   pi_rdata
);

	logic              sck_meta, sck_s, sck_d;
	logic              mosi_meta, mosi_s;
	logic              ss_meta, ss_s;
	logic              sck_rise, sck_fall;
	logic [2:0]        bit_cnt;
	logic [2:0]        byte_cnt;  // counts header bytes, stops at 5
	logic              data_phase;
	logic [7:0]        cmd;
	logic [31:0]       addr;
	logic [6:0]        rx_sr;
	io_bus_pkg::data_t rx_byte;
	io_bus_pkg::data_t rd_buf;    // next byte to be shifted out
	logic [7:0]        tx_sr;
	logic              byte_done;
	logic              is_wr, is_rd;
	logic              issue;
	logic [31:0]       req_addr;

	// the SPI pins are asynchronous to clk, so every one goes through two flops
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sck_meta <= 1'b0;
			sck_s    <= 1'b0;
			sck_d    <= 1'b0;
			ss_meta  <= 1'b1;
			ss_s     <= 1'b1;
		end
		else
		begin
			sck_meta <= sck;
			sck_s    <= sck_meta;
			sck_d    <= sck_s; // previous level for edge detection
			ss_meta  <= ss_n;
			ss_s     <= ss_meta;
		end
	end

	always_ff @(posedge clk)
	begin
		mosi_meta <= mosi;
		mosi_s    <= mosi_meta;
	end

	assign sck_rise  = ~ss_s & sck_s & ~sck_d;
	assign sck_fall  = ~ss_s & ~sck_s & sck_d;
	assign rx_byte   = {rx_sr, mosi_s}; // byte including the bit sampled right now
	assign byte_done = sck_rise & (bit_cnt == 3'd7);

	assign is_wr = cmd == io_map_pkg::CMD_MEM_WR;
	assign is_rd = cmd == io_map_pkg::CMD_MEM_RD;

	// the last header byte is the top address byte, so it is merged in directly
	assign req_addr = data_phase ? addr : {rx_byte, addr[23:0]};

	// a read goes out as soon as the address is complete, writes wait for their data byte
	assign issue = byte_done & (data_phase ? (is_wr | is_rd) : (byte_cnt == 3'd4) & is_rd);

	assign miso = ss_n | tx_sr[7]; // idles high outside a transaction

	always_ff @(posedge clk)
	begin
		if (rst || ss_s)
		begin
			bit_cnt    <= 3'd0;
			byte_cnt   <= 3'd0;
			data_phase <= 1'b0;
			cmd        <= 8'h00;
			rd_buf     <= 8'hFF;
			tx_sr      <= 8'hFF;
			pi_req     <= '0;
		end
		else
		begin
			pi_req.valid <= 1'b0;

			if (sck_rise)
				bit_cnt <= bit_cnt + 3'd1;

			if (byte_done && !data_phase)
			begin
				if (byte_cnt == 3'd0)
					cmd <= rx_byte;
				if (byte_cnt == 3'd4)
					data_phase <= 1'b1;
				byte_cnt <= byte_cnt + 3'd1;
			end

			// unknown commands never reach this point, their data bytes just pass
			if (issue)
			begin
				pi_req.valid <= 1'b1;
				pi_req.we    <= is_wr;
				pi_req.addr  <= req_addr;
				pi_req.wdata <= rx_byte;
			end

			// the register block answers in the same cycle as the request
			if (pi_req.valid && !pi_req.we)
				rd_buf <= pi_rdata;

			// bit_cnt has wrapped to zero on the falling edge that starts a new byte
			if (sck_fall)
				tx_sr <= (bit_cnt == 3'd0) ? rd_buf : {tx_sr[6:0], 1'b1};
		end
	end

	always_ff @(posedge clk)
	begin
		if (sck_rise)
			rx_sr <= rx_byte[6:0];

		if (byte_done && !data_phase)
		begin
			case (byte_cnt)
				3'd1: addr[7:0]   <= rx_byte; // address arrives least significant byte first
				3'd2: addr[15:8]  <= rx_byte;
				3'd3: addr[23:16] <= rx_byte;
				3'd4: addr[31:24] <= rx_byte;
				default: ;
			endcase
		end

		if (issue)
			addr <= req_addr + 32'd1;
	end

endmodule

// ==== design/io_hub.sv ====
`timescale 1ns/1ps

module io_hub
(
	input  logic                                 clk,
	input  logic                                 rst,
	input  io_bus_pkg::pi_req_t                  pi_req,
	output io_bus_pkg::data_t                    pi_rdata,
	input  io_bus_pkg::cpu_bus_t                 cpu,
	output io_bus_pkg::data_t                    cpu_rdata,
	output logic                                 cpu_oe,
	output logic [io_map_pkg::SYS_CFG_W-1:0]     sys_cfg,
	input  logic                                 mcu_busy,
	output logic                                 mcu_fifo_empty
);

	logic [io_map_pkg::CFG_BYTES-1:0][7:0] cfg;

	logic              pi_cfg_sel, pi_fifo_sel;
	logic              cpu_rd, cpu_wr;
	logic              hit_data, hit_fstat, hit_status;
	logic              to_cpu_push, to_cpu_pop, to_cpu_empty;
	logic              to_mcu_push, to_mcu_pop, to_mcu_empty;
	io_bus_pkg::data_t to_cpu_rdata, to_mcu_rdata;
	io_bus_pkg::data_t to_cpu_head, to_mcu_head;
	logic [7:0]        fifo_stat;
	logic [7:0]        status;
	logic              toggle, cfg_pend, cmd_pend;
	logic              busy_meta, busy_s, busy_d;
	logic              busy_fall;

	// peripheral side decode
	assign pi_cfg_sel  = pi_req.addr[31:3] == io_map_pkg::PI_CFG_BASE[31:3];
	assign pi_fifo_sel = pi_req.addr == io_map_pkg::PI_FIFO_ADDR;

	// an empty FIFO reads as 0xFF on both sides
	assign to_cpu_head = to_cpu_empty ? 8'hFF : to_cpu_rdata;
	assign to_mcu_head = to_mcu_empty ? 8'hFF : to_mcu_rdata;

	assign pi_rdata = pi_cfg_sel  ? cfg[pi_req.addr[2:0]] :
	                  pi_fifo_sel ? to_mcu_head : 8'hFF;

	// host CPU side decode
	assign cpu_rd     = cpu.strobe & cpu.rw;
	assign cpu_wr     = cpu.strobe & ~cpu.rw;
	assign hit_data   = cpu.addr == io_map_pkg::CPU_REG_FIFO_DATA;
	assign hit_fstat  = cpu.addr == io_map_pkg::CPU_REG_FIFO_STAT;
	assign hit_status = cpu.addr == io_map_pkg::CPU_REG_STATUS;

	assign fifo_stat = {to_cpu_empty, to_mcu_empty, 6'd1};
	assign status    = {io_map_pkg::STATUS_SIG, toggle, cfg_pend, cmd_pend, 1'b0};

	assign cpu_oe = cpu_rd & (hit_data | hit_fstat | hit_status);

	always_comb
	begin
		cpu_rdata = 8'hFF;
		if (cpu_rd)
		begin
			if (hit_data)
				cpu_rdata = to_cpu_head;
			else if (hit_fstat)
				cpu_rdata = fifo_stat;
			else if (hit_status)
				cpu_rdata = status; // value before the toggle flips
		end
	end

	// SPI writes feed the CPU, CPU writes feed the controller
	assign to_cpu_push = pi_req.valid & pi_req.we & pi_fifo_sel;
	assign to_cpu_pop  = cpu_rd & hit_data;
	assign to_mcu_push = cpu_wr & hit_data;
	assign to_mcu_pop  = pi_req.valid & ~pi_req.we & pi_fifo_sel;

	byte_fifo fifo_to_cpu
	(
		.clk   (clk),
		.rst   (rst),
		.push  (to_cpu_push),
		.wdata (pi_req.wdata),
		.pop   (to_cpu_pop),
		.rdata (to_cpu_rdata),
		.empty (to_cpu_empty),
		.full  ()
	);

	byte_fifo fifo_to_mcu
	(
		.clk   (clk),
		.rst   (rst),
		.push  (to_mcu_push),
		.wdata (cpu.wdata),
		.pop   (to_mcu_pop),
		.rdata (to_mcu_rdata),
		.empty (to_mcu_empty),
		.full  ()
	);

	assign busy_fall = busy_d & ~busy_s;
	assign sys_cfg   = cfg;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cfg            <= '0;
			toggle         <= 1'b0;
			cfg_pend       <= 1'b0;
			cmd_pend       <= 1'b0;
			busy_meta      <= 1'b0;
			busy_s         <= 1'b0;
			busy_d         <= 1'b0;
			mcu_fifo_empty <= 1'b1;
		end
		else
		begin
			if (pi_req.valid && pi_req.we && pi_cfg_sel)
				cfg[pi_req.addr[2:0]] <= pi_req.wdata;

			if (cpu_rd && hit_status)
				toggle <= ~toggle;

			// the CPU write has priority over the end of a controller command
			if (cpu_wr && hit_status)
				{cfg_pend, cmd_pend} <= cpu.wdata[2:1];
			else if (busy_fall)
				cmd_pend <= 1'b0;

			busy_meta <= mcu_busy;
			busy_s    <= busy_meta;
			busy_d    <= busy_s;

			mcu_fifo_empty <= to_mcu_empty;
		end
	end

endmodule

// ==== design/io_subsys_top.sv ====
`timescale 1ns/1ps

module io_subsys_top
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 sck,
	input  logic                 mosi,
	input  logic                 ss_n,
	output logic                 miso,
	input  io_bus_pkg::cpu_bus_t cpu,
	output logic [7:0]           cpu_rdata,
	output logic                 cpu_oe,
	output logic [63:0]          sys_cfg,
	input  logic                 mcu_busy,
	output logic                 mcu_fifo_empty
);

	io_bus_pkg::pi_req_t pi_req;
	logic [7:0]          pi_rdata;

	// SPI side turns byte commands into single cycle register requests
	spi_target u_spi_target
	(
		.clk      (clk),
		.rst      (rst),
		.sck      (sck),
		.mosi     (mosi),
		.ss_n     (ss_n),
		.miso     (miso),
		.pi_req   (pi_req),
		.pi_rdata (pi_rdata)
	);

	io_hub u_io_hub
	(
		.clk            (clk),
		.rst            (rst),
		.pi_req         (pi_req),
		.pi_rdata       (pi_rdata),
		.cpu            (cpu),
		.cpu_rdata      (cpu_rdata),
		.cpu_oe         (cpu_oe),
		.sys_cfg        (sys_cfg),
		.mcu_busy       (mcu_busy),
		.mcu_fifo_empty (mcu_fifo_empty)
	);

endmodule

// ==== testbench/io_subsys_props.sv ====
`timescale 1ns/1ps

module io_subsys_props
(
	input logic                 clk,
	input logic                 rst,
	input io_bus_pkg::pi_req_t  pi_req,
	input io_bus_pkg::cpu_bus_t cpu,
	input logic                 cpu_oe,
	input io_bus_pkg::data_t    cpu_rdata,
	input logic                 to_cpu_empty,
	input logic                 to_mcu_empty
);

	// requests from the SPI side are single cycle pulses
	a_req_pulse: assert property (@(posedge clk) disable iff (rst) pi_req.valid |=> !pi_req.valid)
		else $error("pi_req.valid stayed high for two cycles");

	// any access that is not a mapped read leaves the data lines at 0xFF
	a_idle_rdata: assert property (@(posedge clk)
		(cpu.strobe && !cpu_oe) |-> (cpu_rdata == 8'hFF))
		else $error("cpu_rdata is not 0xFF on an access without cpu_oe");

	a_reset_empty: assert property (@(posedge clk) rst |=> (to_cpu_empty && to_mcu_empty))
		else $error("a FIFO is not empty after reset");

endmodule

bind io_hub io_subsys_props u_props
(
	.clk          (clk),
	.rst          (rst),
	.pi_req       (pi_req),
	.cpu          (cpu),
	.cpu_oe       (cpu_oe),
	.cpu_rdata    (cpu_rdata),
	.to_cpu_empty (to_cpu_empty),
	.to_mcu_empty (to_mcu_empty)
);

// ==== testbench/tb_io_subsys.sv ====
`timescale 1ns/1ps

module tb_io_subsys;

	localparam int HALF_SCK    = 8;      // clk cycles per sck half period
	// roughly 400 SPI bytes at 128 cycles each come to about 51000 cycles
	localparam int CYCLE_LIMIT = 200000;

	logic                 clk;
	logic                 rst;
	logic                 sck;
	logic                 mosi;
	logic                 ss_n;
	logic                 miso;
	io_bus_pkg::cpu_bus_t cpu;
	logic [7:0]           cpu_rdata;
	logic                 cpu_oe;
	logic [63:0]          sys_cfg;
	logic                 mcu_busy;
	logic                 mcu_fifo_empty;

	integer     seed;
	int         errors;
	int         checks;
	int         cycles = 0;
	logic [7:0] cfg_model [8];
	logic [7:0] q_cpu [$];  // bytes on their way from SPI to the CPU
	logic [7:0] q_mcu [$];  // bytes on their way from the CPU to SPI
	logic [7:0] want_q [$]; // expected bytes of the next SPI read burst
	logic       toggle_m, cfg_pend_m, cmd_pend_m;
	logic [7:0] rd_byte;
	logic       rd_oe;
	logic [31:0] rnd;

	io_subsys_top uut
	(
		.clk            (clk),
		.rst            (rst),
		.sck            (sck),
		.mosi           (mosi),
		.ss_n           (ss_n),
		.miso           (miso),
		.cpu            (cpu),
		.cpu_rdata      (cpu_rdata),
		.cpu_oe         (cpu_oe),
		.sys_cfg        (sys_cfg),
		.mcu_busy       (mcu_busy),
		.mcu_fifo_empty (mcu_fifo_empty)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles == CYCLE_LIMIT)
		begin
			$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("errors: %0d, checks: %0d", errors, checks);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [63:0] want, input logic [63:0] got);
		checks++;
		if (want !== got)
		begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, name, want, got);
		end
	endtask

	// moves to 1 ns after the n-th rising edge from now
	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// one SPI byte MSB first, sck idles low and miso is taken at the rising edge
	task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
		for (int i = 7; i >= 0; i--)
		begin
			mosi = tx[i];
			step(HALF_SCK);
			sck = 1'b1;
			rx[i] = miso;
			step(HALF_SCK);
			sck = 1'b0;
		end
	endtask

	task automatic open_frame(input logic [7:0] cmd, input logic [31:0] addr);
		logic [7:0] unused;
		ss_n = 1'b0;
		shift_byte(cmd, unused);
		for (int i = 0; i < 4; i++)
			shift_byte(addr[8*i +: 8], unused); // least significant byte first
	endtask

	task automatic close_frame();
		step(HALF_SCK);
		ss_n = 1'b1;
		step(4);
	endtask

	task automatic write_byte_spi(input logic [31:0] addr, input logic [7:0] data);
		logic [7:0] unused;
		open_frame(io_map_pkg::CMD_MEM_WR, addr);
		shift_byte(data, unused);
		close_frame();
	endtask

	// reads as many bytes as want_q holds and compares each one
	task automatic read_burst_spi(input logic [31:0] addr);
		logic [7:0] got;
		open_frame(io_map_pkg::CMD_MEM_RD, addr);
		while (want_q.size() > 0)
		begin
			shift_byte(8'h00, got);
			compare("miso byte", want_q.pop_front(), got);
		end
		close_frame();
	endtask

	// single strobe cycle, the read data is taken mid-cycle
	task automatic cpu_access(input logic rw, input logic [15:0] addr, input logic [7:0] wdata,
		output logic [7:0] rdata, output logic oe);
		cpu.addr   = addr;
		cpu.wdata  = wdata;
		cpu.rw     = rw;
		cpu.strobe = 1'b1;
		@(negedge clk);
		rdata = cpu_rdata;
		oe    = cpu_oe;
		step(1);
		cpu = '0;
	endtask

	function automatic logic [63:0] cfg_vector();
		logic [63:0] v;
		for (int i = 0; i < 8; i++)
			v[8*i +: 8] = cfg_model[i];
		return v;
	endfunction

	function automatic logic [7:0] status_value();
		return {4'hA, toggle_m, cfg_pend_m, cmd_pend_m, 1'b0};
	endfunction

	function automatic logic [7:0] fifo_status();
		return {q_cpu.size() == 0, q_mcu.size() == 0, 6'd1};
	endfunction

	task automatic config_roundtrip();
		repeat (8)
		begin
			rnd = $random(seed);
			write_byte_spi(io_map_pkg::PI_CFG_BASE | {29'd0, rnd[2:0]}, rnd[15:8]);
			cfg_model[rnd[2:0]] = rnd[15:8];
			compare("sys_cfg", cfg_vector(), sys_cfg);
		end
		for (int i = 0; i < 8; i++)
			want_q.push_back(cfg_model[i]);
		read_burst_spi(io_map_pkg::PI_CFG_BASE);
	endtask

	task automatic fill_to_cpu(input int n);
		repeat (n)
		begin
			rnd = $random(seed);
			write_byte_spi(io_map_pkg::PI_FIFO_ADDR, rnd[7:0]);
			if (q_cpu.size() < io_map_pkg::FIFO_DEPTH)
				q_cpu.push_back(rnd[7:0]); // a full FIFO drops the byte
		end
	endtask

	task automatic drain_to_cpu();
		int n;
		logic [7:0] want;
		n = q_cpu.size() + 1; // the last read finds the FIFO empty
		repeat (n)
		begin
			cpu_access(1'b1, io_map_pkg::CPU_REG_FIFO_STAT, 8'h00, rd_byte, rd_oe);
			compare("fifo status", fifo_status(), rd_byte);
			want = (q_cpu.size() > 0) ? q_cpu.pop_front() : 8'hFF;
			cpu_access(1'b1, io_map_pkg::CPU_REG_FIFO_DATA, 8'h00, rd_byte, rd_oe);
			compare("cpu_rdata", want, rd_byte);
			compare("cpu_oe", 1, rd_oe);
		end
	endtask

	task automatic fill_to_mcu(input int n);
		repeat (n)
		begin
			rnd = $random(seed);
			cpu_access(1'b0, io_map_pkg::CPU_REG_FIFO_DATA, rnd[7:0], rd_byte, rd_oe);
			compare("cpu_oe on write", 0, rd_oe);
			compare("cpu_rdata on write", 8'hFF, rd_byte);
			if (q_mcu.size() < io_map_pkg::FIFO_DEPTH)
				q_mcu.push_back(rnd[7:0]);
		end
		step(1); // mcu_fifo_empty is registered
		compare("mcu_fifo_empty", q_mcu.size() == 0, mcu_fifo_empty);
	endtask

	// one data byte per frame since the address moves on after every request
	task automatic drain_to_mcu();
		int n;
		n = q_mcu.size() + 1;
		repeat (n)
		begin
			want_q.push_back((q_mcu.size() > 0) ? q_mcu.pop_front() : 8'hFF);
			read_burst_spi(io_map_pkg::PI_FIFO_ADDR);
		end
		compare("mcu_fifo_empty", 1, mcu_fifo_empty);
	endtask

	task automatic read_status();
		cpu_access(1'b1, io_map_pkg::CPU_REG_STATUS, 8'h00, rd_byte, rd_oe);
		compare("status", status_value(), rd_byte);
		toggle_m = ~toggle_m;
	endtask

	task automatic status_register();
		repeat (4) read_status();
		mcu_busy = 1'b1;
		step(4);
		cpu_access(1'b0, io_map_pkg::CPU_REG_STATUS, 8'h06, rd_byte, rd_oe);
		cfg_pend_m = 1'b1;
		cmd_pend_m = 1'b1;
		read_status();
		mcu_busy = 1'b0;
		step(2);
		read_status(); // two flops of the synchronizer, cmd_pend still set
		cmd_pend_m = 1'b0;
		read_status(); // edge register done, third cycle after the drop
	endtask

	task automatic unmapped_access();
		repeat (6)
		begin
			rnd = $random(seed);
			cpu_access(1'b1, {1'b1, rnd[14:0]}, 8'h00, rd_byte, rd_oe);
			compare("cpu_oe unmapped", 0, rd_oe);
			compare("cpu_rdata unmapped", 8'hFF, rd_byte);
		end
		cpu_access(1'b1, 16'h40F2, 8'h00, rd_byte, rd_oe);
		compare("cpu_oe unmapped", 0, rd_oe);
		cpu_access(1'b0, io_map_pkg::CPU_REG_FIFO_STAT, 8'h5A, rd_byte, rd_oe);
		compare("cpu_oe on write", 0, rd_oe);
		compare("cpu_rdata on write", 8'hFF, rd_byte);
	endtask

	initial
	begin
		seed       = 58745;
		errors     = 0;
		checks     = 0;
		rst        = 1'b1;
		sck        = 1'b0;
		mosi       = 1'b0;
		ss_n       = 1'b1;
		cpu        = '0;
		mcu_busy   = 1'b0;
		toggle_m   = 1'b0;
		cfg_pend_m = 1'b0;
		cmd_pend_m = 1'b0;
		for (int i = 0; i < 8; i++)
			cfg_model[i] = 8'h00;
		step(5);
		rst = 1'b0;
		step(2);
		compare("sys_cfg", 64'd0, sys_cfg);
		compare("miso", 1, miso);
		compare("mcu_fifo_empty", 1, mcu_fifo_empty);

		config_roundtrip();
		rnd = $random(seed);
		fill_to_cpu(1 + rnd[2:0]);
		drain_to_cpu();
		rnd = $random(seed);
		fill_to_mcu(1 + rnd[2:0]);
		drain_to_mcu();
		fill_to_cpu(20); // overflow in both directions
		drain_to_cpu();
		fill_to_mcu(20);
		drain_to_mcu();
		status_register();
		unmapped_access();

		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== files.f ====
design/io_map_pkg.sv
design/io_bus_pkg.sv
design/byte_fifo.sv
design/spi_target.sv
design/io_hub.sv
design/io_subsys_top.sv
testbench/io_subsys_props.sv
testbench/tb_io_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# a build error or an aborted run also ends up as a failure in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_io_subsys -f files.f \
	-o tb_io_subsys && ./obj_dir/tb_io_subsys > sim.log 2>&1 || echo "=== FAIL ===" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
